// ==== hdl/board_ctrl_pkg.sv ====
//----------------------------------------------------------
// board control package
// register map, firmware stamps and shared bus types
//----------------------------------------------------------
package board_ctrl_pkg;

    //----------------------------------------------------------
    // widths
    //----------------------------------------------------------
    localparam int REG_DW     = 16;
    localparam int REG_AW     = 8;
    localparam int ETH_PORTS  = 4;
    localparam int TEST_REGS  = 8;
    localparam int FRAME_BITS = REG_AW + REG_DW;       // address then data
    localparam int CNT_W      = $clog2(FRAME_BITS + 1);

    // addresses at or above this are reads
    localparam logic [REG_AW-1:0] RD_OFFSET = 8'h80;

    //----------------------------------------------------------
    // write map
    //----------------------------------------------------------
    localparam logic [REG_AW-1:0] WREG_TEST    = 8'd0;  // TEST_REGS entries
    localparam logic [REG_AW-1:0] WREG_PHY_RST = 8'd8;
    localparam logic [REG_AW-1:0] WREG_MDC     = 8'd9;
    localparam logic [REG_AW-1:0] WREG_MDIO_DO = 8'd10;
    localparam logic [REG_AW-1:0] WREG_MDIO_OE = 8'd11;

    //----------------------------------------------------------
    // read map, offsets from RD_OFFSET
    //----------------------------------------------------------
    localparam logic [REG_AW-1:0] RREG_FW_DATE = 8'd0;  // two words, low first
    localparam logic [REG_AW-1:0] RREG_FW_TIME = 8'd2;
    localparam logic [REG_AW-1:0] RREG_FW_TYPE = 8'd4;
    localparam logic [REG_AW-1:0] RREG_LINK    = 8'd5;
    localparam logic [REG_AW-1:0] RREG_RXERR   = 8'd6;  // two words per port
    localparam logic [REG_AW-1:0] RREG_PHY_RST = 8'd14;
    localparam logic [REG_AW-1:0] RREG_MDC     = 8'd15;
    localparam logic [REG_AW-1:0] RREG_MDIO_DO = 8'd16;
    localparam logic [REG_AW-1:0] RREG_MDIO_OE = 8'd17;
    localparam logic [REG_AW-1:0] RREG_MDIO_DI = 8'd18;
    localparam logic [REG_AW-1:0] RREG_TEST    = 8'd19;

    // build stamps
    localparam logic [2*REG_DW-1:0] FW_DATE = 32'h5A3C_0E17;
    localparam logic [2*REG_DW-1:0] FW_TIME = 32'h0013_2745;
    localparam logic [REG_DW-1:0]   FW_TYPE = 16'h0B41;

    //----------------------------------------------------------
    // bus types
    //----------------------------------------------------------
    typedef struct packed {
        logic              wr;    // one cycle strobe
        logic [REG_AW-1:0] addr;
        logic [REG_DW-1:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic [ETH_PORTS-1:0] phy_rst;
        logic                 mdc;
        logic                 mdio_do;
        logic                 mdio_oe;
    } phy_ctrl_t;

    typedef struct packed {
        logic [ETH_PORTS-1:0]               link;
        logic [ETH_PORTS-1:0][2*REG_DW-1:0] rxerr;  // rx error counter per port
    } port_status_t;

    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_ADDR,
        SPI_WDATA,
        SPI_RDATA
    } spi_state_e;

endpackage

// ==== hdl/spi_reg_slave.sv ====
`timescale 1ns/1ns
//----------------------------------------------------------
// SPI mode 0 register slave sampled on reg_clk
// turns address/data frames into register writes and reads
//----------------------------------------------------------
module spi_reg_slave (
    input  logic                              reg_clk,
    input  logic                              arst_n_i,
    input  logic                              spi_sclk_i,
    input  logic                              spi_cs_n_i,
    input  logic                              spi_mosi_i,
    output logic                              spi_miso_o,
    output board_ctrl_pkg::reg_wr_t           reg_wr_o,
    output logic [board_ctrl_pkg::REG_AW-1:0] rd_addr_o,
    input  logic [board_ctrl_pkg::REG_DW-1:0] rd_data_i
);
    import board_ctrl_pkg::*;

    logic [1:0]        sclk_sync;
    logic [1:0]        cs_sync;
    logic [1:0]        mosi_sync;
    logic              sclk_d;
    logic              sclk_rise;
    logic              sclk_fall;
    logic              cs_n_s;
    logic              mosi_s;
    logic [REG_DW-1:0] shift_in;

    spi_state_e        state_q;
    logic [CNT_W-1:0]  bit_cnt_q;    // SCLK rising edges in this frame
    logic [REG_DW-1:0] shreg_q;
    logic [REG_AW-1:0] addr_q;
    logic              load_q;       // read data is captured next cycle
    logic              wr_q;
    logic              miso_q;

    //----------------------------------------------------------
    // pin synchronisers and edge detect
    //----------------------------------------------------------
    always_ff @(posedge reg_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sclk_sync <= '0;
            cs_sync   <= 2'b11;      // deselected
            mosi_sync <= '0;
            sclk_d    <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], spi_sclk_i};
            cs_sync   <= {cs_sync[0], spi_cs_n_i};
            mosi_sync <= {mosi_sync[0], spi_mosi_i};
            sclk_d    <= sclk_sync[1];
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_d;
    assign sclk_fall = ~sclk_sync[1] & sclk_d;
    assign cs_n_s    = cs_sync[1];
    assign mosi_s    = mosi_sync[1];
    assign shift_in  = {shreg_q[REG_DW-2:0], mosi_s};   // MSB first

    //----------------------------------------------------------
    // frame FSM
    //----------------------------------------------------------
    always_ff @(posedge reg_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= SPI_IDLE;
            bit_cnt_q <= '0;
            shreg_q   <= '0;
            addr_q    <= '0;
            load_q    <= 1'b0;
            wr_q      <= 1'b0;
            miso_q    <= 1'b0;
        end else begin
            wr_q   <= 1'b0;
            load_q <= 1'b0;
            if (cs_n_s) begin
                // deselect ends or aborts the frame
                state_q <= SPI_IDLE;
                miso_q  <= 1'b0;
            end else begin
                case (state_q)
                    SPI_IDLE: begin
                        state_q   <= SPI_ADDR;
                        bit_cnt_q <= '0;
                    end
                    SPI_ADDR: begin
                        if (sclk_rise) begin
                            shreg_q   <= shift_in;
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            if (bit_cnt_q == CNT_W'(REG_AW - 1)) begin
                                addr_q <= shift_in[REG_AW-1:0];
                                if (shift_in[REG_AW-1:0] >= RD_OFFSET) begin
                                    state_q <= SPI_RDATA;
                                    load_q  <= 1'b1;
                                end else begin
                                    state_q <= SPI_WDATA;
                                end
                            end
                        end
                    end
                    SPI_WDATA: begin
                        if (sclk_rise && bit_cnt_q < CNT_W'(FRAME_BITS)) begin
                            shreg_q   <= shift_in;
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            if (bit_cnt_q == CNT_W'(FRAME_BITS - 1)) begin
                                wr_q <= 1'b1;    // last data bit in
                            end
                        end
                    end
                    SPI_RDATA: begin
                        if (load_q) begin
                            shreg_q <= rd_data_i;
                            miso_q  <= rd_data_i[REG_DW-1];
                        end else if (sclk_fall && bit_cnt_q != CNT_W'(REG_AW)) begin
                            // first fall after the address keeps the MSB
                            shreg_q <= shreg_q << 1;
                            miso_q  <= shreg_q[REG_DW-2];
                        end
                        if (sclk_rise && bit_cnt_q < CNT_W'(FRAME_BITS)) begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end
                    default: state_q <= SPI_IDLE;
                endcase
            end
        end
    end

    // data bits end up in shreg once the frame is complete
    assign reg_wr_o   = '{wr: wr_q, addr: addr_q, data: shreg_q};
    assign rd_addr_o  = addr_q;
    assign spi_miso_o = miso_q;

    //----------------------------------------------------------
    // checks
    //----------------------------------------------------------
    a_wr_inside_frame: assert property (@(posedge reg_clk) disable iff (!arst_n_i)
        reg_wr_o.wr |-> !cs_n_s);

    a_rdata_addr: assert property (@(posedge reg_clk) disable iff (!arst_n_i)
        (state_q == SPI_RDATA) |-> (addr_q >= RD_OFFSET));

endmodule

// ==== hdl/board_regs.sv ====
`timescale 1ns/1ns
//----------------------------------------------------------
// board register file
// test array, PHY reset and MDIO bit-bang controls, read mux
//----------------------------------------------------------
module board_regs (
    input  logic                              reg_clk,
    input  logic                              arst_n_i,
    input  board_ctrl_pkg::reg_wr_t           reg_wr_i,
    input  logic [board_ctrl_pkg::REG_AW-1:0] rd_addr_i,
    output logic [board_ctrl_pkg::REG_DW-1:0] rd_data_o,
    input  board_ctrl_pkg::port_status_t      status_i,
    input  logic                              mdio_di_i,
    output board_ctrl_pkg::phy_ctrl_t         phy_ctrl_o
);
    import board_ctrl_pkg::*;

    logic [1:0]        mdio_di_sync;
    logic [REG_DW-1:0] test_q [TEST_REGS];
    phy_ctrl_t         ctrl_q;
    logic              rd_hit;
    logic [REG_AW-1:0] rd_idx;

    // mdio pin comes from the PHY, async to reg_clk
    always_ff @(posedge reg_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mdio_di_sync <= '0;
        end else begin
            mdio_di_sync <= {mdio_di_sync[0], mdio_di_i};
        end
    end

    //----------------------------------------------------------
    // write decode
    //----------------------------------------------------------
    always_ff @(posedge reg_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < TEST_REGS; i++) begin
                test_q[i] <= '0;
            end
            ctrl_q <= '0;     // PHYs held in reset, mdio released
        end else if (reg_wr_i.wr) begin
            for (int i = 0; i < TEST_REGS; i++) begin
                if (reg_wr_i.addr == WREG_TEST + REG_AW'(i)) begin
                    test_q[i] <= reg_wr_i.data;
                end
            end
            case (reg_wr_i.addr)
                WREG_PHY_RST: ctrl_q.phy_rst <= reg_wr_i.data[ETH_PORTS-1:0];
                WREG_MDC:     ctrl_q.mdc     <= reg_wr_i.data[0];
                WREG_MDIO_DO: ctrl_q.mdio_do <= reg_wr_i.data[0];
                WREG_MDIO_OE: ctrl_q.mdio_oe <= reg_wr_i.data[0];
                default: ;
            endcase
        end
    end

    assign phy_ctrl_o = ctrl_q;

    //----------------------------------------------------------
    // read mux
    //----------------------------------------------------------
    assign rd_hit = (rd_addr_i >= RD_OFFSET);
    assign rd_idx = rd_addr_i - RD_OFFSET;

    always_comb begin
        rd_data_o = '0;                  // unmapped reads give 0
        if (rd_hit) begin
            case (rd_idx)
                RREG_FW_DATE:        rd_data_o = FW_DATE[REG_DW-1:0];
                RREG_FW_DATE + 1'b1: rd_data_o = FW_DATE[2*REG_DW-1:REG_DW];
                RREG_FW_TIME:        rd_data_o = FW_TIME[REG_DW-1:0];
                RREG_FW_TIME + 1'b1: rd_data_o = FW_TIME[2*REG_DW-1:REG_DW];
                RREG_FW_TYPE:        rd_data_o = FW_TYPE;
                RREG_LINK:           rd_data_o = REG_DW'(status_i.link);
                RREG_PHY_RST:        rd_data_o = REG_DW'(ctrl_q.phy_rst);
                RREG_MDC:            rd_data_o = REG_DW'(ctrl_q.mdc);
                RREG_MDIO_DO:        rd_data_o = REG_DW'(ctrl_q.mdio_do);
                RREG_MDIO_OE:        rd_data_o = REG_DW'(ctrl_q.mdio_oe);
                RREG_MDIO_DI:        rd_data_o = REG_DW'(mdio_di_sync[1]);
                default: ;
            endcase
            // error counters, low half first
            for (int p = 0; p < ETH_PORTS; p++) begin
                if (rd_idx == RREG_RXERR + REG_AW'(2 * p)) begin
                    rd_data_o = status_i.rxerr[p][REG_DW-1:0];
                end
                if (rd_idx == RREG_RXERR + REG_AW'(2 * p + 1)) begin
                    rd_data_o = status_i.rxerr[p][2*REG_DW-1:REG_DW];
                end
            end
            for (int i = 0; i < TEST_REGS; i++) begin
                if (rd_idx == RREG_TEST + REG_AW'(i)) begin
                    rd_data_o = test_q[i];
                end
            end
        end
    end

    // driver enable only turns on from a host write
    a_oe_by_write: assert property (@(posedge reg_clk) disable iff (!arst_n_i)
        $rose(ctrl_q.mdio_oe) |-> $past(reg_wr_i.wr && reg_wr_i.addr == WREG_MDIO_OE));

endmodule

// ==== hdl/board_ctrl_top.sv ====
`timescale 1ns/1ns
//----------------------------------------------------------
// board control top, SPI slave beside its register file
//----------------------------------------------------------
module board_ctrl_top (
    input  logic                                 reg_clk,
    input  logic                                 arst_n_i,
    input  logic                                 spi_sclk_i,
    input  logic                                 spi_cs_n_i,
    input  logic                                 spi_mosi_i,
    output logic                                 spi_miso_o,
    input  board_ctrl_pkg::port_status_t         status_i,
    input  logic                                 mdio_di_i,
    output logic [board_ctrl_pkg::ETH_PORTS-1:0] phy_rst_o,
    output logic                                 mdc_o,
    output logic                                 mdio_do_o,
    output logic                                 mdio_oe_o
);
    import board_ctrl_pkg::*;

    reg_wr_t           reg_wr;
    logic [REG_AW-1:0] rd_addr;
    logic [REG_DW-1:0] rd_data;
    phy_ctrl_t         phy_ctrl;

    spi_reg_slave u_spi (
        .reg_clk    (reg_clk),
        .arst_n_i   (arst_n_i),
        .spi_sclk_i (spi_sclk_i),
        .spi_cs_n_i (spi_cs_n_i),
        .spi_mosi_i (spi_mosi_i),
        .spi_miso_o (spi_miso_o),
        .reg_wr_o   (reg_wr),
        .rd_addr_o  (rd_addr),
        .rd_data_i  (rd_data)
    );

    board_regs u_regs (
        .reg_clk    (reg_clk),
        .arst_n_i   (arst_n_i),
        .reg_wr_i   (reg_wr),
        .rd_addr_i  (rd_addr),
        .rd_data_o  (rd_data),
        .status_i   (status_i),
        .mdio_di_i  (mdio_di_i),
        .phy_ctrl_o (phy_ctrl)
    );

    // PHY pins
    assign phy_rst_o = phy_ctrl.phy_rst;
    assign mdc_o     = phy_ctrl.mdc;
    assign mdio_do_o = phy_ctrl.mdio_do;
    assign mdio_oe_o = phy_ctrl.mdio_oe;  // tristate sits in the pad ring

endmodule

// ==== bench/tb_clkgen.sv ====
`timescale 1ns/1ns
//----------------------------------------------------------
// testbench clock and reset, 20 ns reg_clk
//----------------------------------------------------------
module tb_clkgen (
    output logic reg_clk,
    output logic arst_n_o
);
    localparam int HALF_NS    = 10;
    localparam int RST_CYCLES = 8;

    initial begin
        reg_clk = 1'b0;
        forever #(HALF_NS) reg_clk = ~reg_clk;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge reg_clk);
        @(negedge reg_clk);
        arst_n_o = 1'b1;     // release away from the sampling edge
    end

endmodule

// ==== bench/tb_board_ctrl.sv ====
`timescale 1ns/1ns
//----------------------------------------------------------
// board control testbench
// SPI master, register map model and random tests
//----------------------------------------------------------
module tb_board_ctrl;
    import board_ctrl_pkg::*;

    localparam logic [31:0] SEED = 32'h351db38b;
    localparam int HALF    = 5;        // SPI half period in reg_clk cycles
    localparam int SETTLE  = 6;        // wait after a write frame
    localparam int GAP     = 4;        // chip select high between reads
    localparam int MODEL_N = 32;
    localparam int ROUNDS  = 3;
    // reset 12, array 16, firmware 5, then status 13, ctrl 9, abort 13 per round
    localparam int N_FRAMES = 12 + 16 + 5 + ROUNDS * (13 + 9 + 13);
    localparam int LIMIT    = N_FRAMES * FRAME_BITS * 10 + 2000;

    logic                 reg_clk;
    logic                 arst_n;
    logic                 spi_sclk;
    logic                 spi_cs_n;
    logic                 spi_mosi;
    logic                 spi_miso;
    port_status_t         status;
    logic                 mdio_di;
    logic [ETH_PORTS-1:0] phy_rst;
    logic                 mdc;
    logic                 mdio_do;
    logic                 mdio_oe;

    logic [REG_DW-1:0] model [MODEL_N];   // mirror of the read map
    int checks   = 0;
    int errors   = 0;
    int t_checks = 0;
    int t_errors = 0;
    int cycles   = 0;

    tb_clkgen u_clkgen (
        .reg_clk  (reg_clk),
        .arst_n_o (arst_n)
    );

    board_ctrl_top uut (
        .reg_clk    (reg_clk),
        .arst_n_i   (arst_n),
        .spi_sclk_i (spi_sclk),
        .spi_cs_n_i (spi_cs_n),
        .spi_mosi_i (spi_mosi),
        .spi_miso_o (spi_miso),
        .status_i   (status),
        .mdio_di_i  (mdio_di),
        .phy_rst_o  (phy_rst),
        .mdc_o      (mdc),
        .mdio_do_o  (mdio_do),
        .mdio_oe_o  (mdio_oe)
    );

    //----------------------------------------------------------
    // SPI master, mode 0
    //----------------------------------------------------------
    task automatic spi_frame(input logic [REG_AW-1:0] addr, input logic [REG_DW-1:0] wdata,
                             input int nbits, output logic [REG_DW-1:0] rdata);
        logic [FRAME_BITS-1:0] frame;
        frame = {addr, wdata};
        rdata = '0;
        spi_cs_n = 1'b0;
        for (int b = 0; b < nbits; b++) begin
            spi_mosi = frame[FRAME_BITS-1-b];        // MSB first, while SCLK low
            repeat (HALF) @(negedge reg_clk);
            if (b >= REG_AW) begin
                rdata = {rdata[REG_DW-2:0], spi_miso};
            end
            spi_sclk = 1'b1;
            repeat (HALF) @(negedge reg_clk);
            spi_sclk = 1'b0;
        end
        spi_cs_n = 1'b1;
        spi_mosi = 1'b0;
    endtask

    task automatic check(input string name, input logic [REG_DW-1:0] exp,
                         input logic [REG_DW-1:0] got);
        checks++;
        t_checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected 0x%04h, got 0x%04h",
                     $time, name, exp, got);
            errors++;
            t_errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks, %0d errors", name, t_checks, t_errors);
        t_checks = 0;
        t_errors = 0;
    endtask

    task automatic write_reg(input logic [REG_AW-1:0] addr, input logic [REG_DW-1:0] data);
        logic [REG_DW-1:0] unused;
        spi_frame(addr, data, FRAME_BITS, unused);
        repeat (SETTLE) @(negedge reg_clk);
        // single bit registers keep bit 0 only
        if (addr < TEST_REGS) begin
            model[RREG_TEST + addr] = data;
        end else if (addr == WREG_PHY_RST) begin
            model[RREG_PHY_RST] = REG_DW'(data[ETH_PORTS-1:0]);
        end else if (addr == WREG_MDC) begin
            model[RREG_MDC] = REG_DW'(data[0]);
        end else if (addr == WREG_MDIO_DO) begin
            model[RREG_MDIO_DO] = REG_DW'(data[0]);
        end else if (addr == WREG_MDIO_OE) begin
            model[RREG_MDIO_OE] = REG_DW'(data[0]);
        end
    endtask

    task automatic read_check(input logic [REG_AW-1:0] addr);
        logic [REG_DW-1:0] got;
        logic [REG_DW-1:0] exp;
        logic [REG_AW-1:0] idx;
        idx = addr - RD_OFFSET;
        exp = (idx < MODEL_N) ? model[idx] : '0;   // unmapped reads are 0
        spi_frame(addr, '0, FRAME_BITS, got);
        repeat (GAP) @(negedge reg_clk);
        check($sformatf("spi_miso_o word at 0x%02h", addr), exp, got);
    endtask

    task automatic check_outputs();
        check("phy_rst_o", model[RREG_PHY_RST], REG_DW'(phy_rst));
        check("mdc_o", model[RREG_MDC], REG_DW'(mdc));
        check("mdio_do_o", model[RREG_MDIO_DO], REG_DW'(mdio_do));
        check("mdio_oe_o", model[RREG_MDIO_OE], REG_DW'(mdio_oe));
    endtask

    task automatic read_all_rw();
        for (int i = 0; i < TEST_REGS; i++) begin
            read_check(REG_AW'(RD_OFFSET + RREG_TEST + i));
        end
        for (int i = RREG_PHY_RST; i <= RREG_MDIO_OE; i++) begin
            read_check(REG_AW'(RD_OFFSET + i));
        end
    endtask

    // run limit
    always @(posedge reg_clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    //----------------------------------------------------------
    // tests
    //----------------------------------------------------------
    initial begin
        logic [REG_DW-1:0] d;
        logic [REG_DW-1:0] cur;
        logic [REG_AW-1:0] a;
        int                n;
        int                seed_init;
        seed_init = $urandom(SEED);
        spi_sclk = 1'b0;
        spi_cs_n = 1'b1;
        spi_mosi = 1'b0;
        status   = '0;
        mdio_di  = 1'b0;
        for (int i = 0; i < MODEL_N; i++) begin
            model[i] = '0;
        end
        model[RREG_FW_DATE]     = FW_DATE[REG_DW-1:0];
        model[RREG_FW_DATE + 1] = FW_DATE[2*REG_DW-1:REG_DW];
        model[RREG_FW_TIME]     = FW_TIME[REG_DW-1:0];
        model[RREG_FW_TIME + 1] = FW_TIME[2*REG_DW-1:REG_DW];
        model[RREG_FW_TYPE]     = FW_TYPE;
        @(posedge arst_n);
        @(negedge reg_clk);

        check_outputs();
        read_all_rw();
        end_test("reset defaults");

        for (int i = 0; i < TEST_REGS; i++) begin
            write_reg(REG_AW'(WREG_TEST + i), REG_DW'($urandom));
        end
        for (int i = 0; i < TEST_REGS; i++) begin
            read_check(REG_AW'(RD_OFFSET + RREG_TEST + i));
        end
        end_test("test array");

        for (int i = 0; i < 5; i++) begin
            read_check(REG_AW'(RD_OFFSET + RREG_FW_DATE + i));
        end
        end_test("firmware stamps");

        for (int r = 0; r < ROUNDS; r++) begin
            status.link = ETH_PORTS'($urandom);     // stable for the whole round
            model[RREG_LINK] = REG_DW'(status.link);
            for (int p = 0; p < ETH_PORTS; p++) begin
                status.rxerr[p] = $urandom;
                model[RREG_RXERR + 2 * p]     = status.rxerr[p][REG_DW-1:0];
                model[RREG_RXERR + 2 * p + 1] = status.rxerr[p][2*REG_DW-1:REG_DW];
            end
            read_check(REG_AW'(RD_OFFSET + RREG_LINK));
            for (int i = 0; i < 2 * ETH_PORTS; i++) begin
                read_check(REG_AW'(RD_OFFSET + RREG_RXERR + i));
            end
            for (int i = 0; i < 4; i++) begin
                n = int'($urandom % 101);             // past the last test register
                read_check(REG_AW'(RD_OFFSET + RREG_TEST + TEST_REGS + n));
            end
        end
        end_test("port status");

        for (int r = 0; r < ROUNDS; r++) begin
            for (int i = WREG_PHY_RST; i <= WREG_MDIO_OE; i++) begin
                write_reg(REG_AW'(i), REG_DW'($urandom));
            end
            check_outputs();
            for (int i = RREG_PHY_RST; i <= RREG_MDIO_OE; i++) begin
                read_check(REG_AW'(RD_OFFSET + i));
            end
            mdio_di = 1'($urandom);
            model[RREG_MDIO_DI] = REG_DW'(mdio_di);
            read_check(REG_AW'(RD_OFFSET + RREG_MDIO_DI));
        end
        end_test("phy and mdio controls");

        for (int r = 0; r < ROUNDS; r++) begin
            a   = REG_AW'($urandom % (WREG_MDIO_OE + 1));
            cur = (a < TEST_REGS) ? model[RREG_TEST + a] : model[RREG_PHY_RST + a - WREG_PHY_RST];
            n   = int'(1 + $urandom % (FRAME_BITS - 1));
            spi_frame(a, ~cur, n, d);                // cut short, no write expected
            repeat (SETTLE) @(negedge reg_clk);
            check_outputs();
            read_all_rw();
        end
        end_test("aborted frames");

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
hdl/board_ctrl_pkg.sv
hdl/spi_reg_slave.sv
hdl/board_regs.sv
hdl/board_ctrl_top.sv
bench/tb_clkgen.sv
bench/tb_board_ctrl.sv
